//--- core_pkg.sv
/*
  Shared widths, register counts, RISC-V opcodes, micro-op class codes
  and the instruction-word union with its R, I and S views
*/
package core_pkg;

  localparam int xlen = 32;
  localparam int reg_index_width = 5;
  localparam int arch_regs = 32;
  localparam int default_decode_width = 4;
  localparam int default_wb_ports = 4;
  localparam int uop_class_width = 2;
  localparam int mem_offset_width = 12;

  // Major opcodes handled by decode
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;

  // Micro-op classes
  localparam logic [uop_class_width-1:0] class_int = 2'd0;
  localparam logic [uop_class_width-1:0] class_load = 2'd1;
  localparam logic [uop_class_width-1:0] class_store = 2'd2;

  // One instruction word, read through whichever format applies
  typedef union packed {
    struct packed {
      logic [6:0]                 funct7;
      logic [reg_index_width-1:0] rs2;
      logic [reg_index_width-1:0] rs1;
      logic [2:0]                 funct3;
      logic [reg_index_width-1:0] rd;
      logic [6:0]                 opcode;
    } r_view;
    struct packed {
      logic [11:0]                imm;
      logic [reg_index_width-1:0] rs1;
      logic [2:0]                 funct3;
      logic [reg_index_width-1:0] rd;
      logic [6:0]                 opcode;
    } i_view;
    struct packed {
      logic [6:0]                 imm_hi;
      logic [reg_index_width-1:0] rs2;
      logic [reg_index_width-1:0] rs1;
      logic [2:0]                 funct3;
      logic [4:0]                 imm_lo;
      logic [6:0]                 opcode;
    } s_view;
  } rv_inst_u;

endpackage

//--- fetch_latch.sv
/*
  Register between fetch and decode, qualifies the slot valids
  and inserts bubbles on stall or flush
*/
`timescale 1ns/1ns

module fetch_latch #(
  parameter int decode_width = core_pkg::default_decode_width
) (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   flush,
  input  logic                                   issue_full,
  input  logic                                   fetch_valid,
  input  logic [core_pkg::xlen-1:0]              fetch_pc,
  input  logic [decode_width*core_pkg::xlen-1:0] fetch_data,
  input  logic [decode_width-1:0]                fetch_slot_valid,
  output logic [decode_width*core_pkg::xlen-1:0] inst,
  output logic [core_pkg::xlen-1:0]              inst_pc,
  output logic [decode_width-1:0]                inst_valid
);

  // Words and pc follow the input, only the valids decide what is live
  always_ff @(posedge clock) begin
    inst    <= fetch_data;
    inst_pc <= fetch_pc;
  end

  always_ff @(posedge clock) begin
    if (reset || flush || issue_full) begin
      inst_valid <= '0;
    end else begin
      inst_valid <= fetch_slot_valid & {decode_width{fetch_valid}};
    end
  end

  // A flushed bundle never reaches decode
  assert property (@(posedge clock) disable iff (reset) flush |=> inst_valid == '0);

endmodule

//--- inst_decode.sv
/*
  Combinational decode of each bundle slot into class, register
  indices, write and source enables and the memory offset
*/
`timescale 1ns/1ns

module inst_decode #(
  parameter int decode_width = core_pkg::default_decode_width
) (
  input  logic [decode_width*core_pkg::xlen-1:0]             inst,
  input  logic [decode_width-1:0]                            inst_valid,
  output logic [decode_width-1:0]                            uop_valid,
  output logic [decode_width*core_pkg::uop_class_width-1:0]  uop_class,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  rd,
  output logic [decode_width-1:0]                            rd_valid,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  rs1,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  rs2,
  output logic [decode_width-1:0]                            rs2_used,
  output logic [decode_width*core_pkg::mem_offset_width-1:0] mem_offset
);

  import core_pkg::*;

  always_comb begin
    rv_inst_u word;
    logic     writes;
    for (int i = 0; i < decode_width; i++) begin
      word = inst[i*xlen +: xlen];
      writes = 1'b0;
      uop_valid[i] = inst_valid[i];
      uop_class[i*uop_class_width +: uop_class_width] = class_int;
      rd[i*reg_index_width +: reg_index_width] = word.r_view.rd;
      rs1[i*reg_index_width +: reg_index_width] = word.r_view.rs1;
      rs2[i*reg_index_width +: reg_index_width] = '0;
      rs2_used[i] = 1'b0;
      mem_offset[i*mem_offset_width +: mem_offset_width] = '0;
      case (word.r_view.opcode)
        opcode_op: begin
          writes = 1'b1;
          rs2[i*reg_index_width +: reg_index_width] = word.r_view.rs2;
          rs2_used[i] = 1'b1;
        end
        opcode_op_imm: begin
          writes = 1'b1;
        end
        opcode_lui: begin
          // Upper immediate, no sources at all
          writes = 1'b1;
          rs1[i*reg_index_width +: reg_index_width] = '0;
        end
        opcode_load: begin
          writes = 1'b1;
          uop_class[i*uop_class_width +: uop_class_width] = class_load;
          mem_offset[i*mem_offset_width +: mem_offset_width] = word.i_view.imm;
        end
        opcode_store: begin
          uop_class[i*uop_class_width +: uop_class_width] = class_store;
          rd[i*reg_index_width +: reg_index_width] = '0;
          rs2[i*reg_index_width +: reg_index_width] = word.s_view.rs2;
          rs2_used[i] = 1'b1;
          mem_offset[i*mem_offset_width +: mem_offset_width] =
            {word.s_view.imm_hi, word.s_view.imm_lo};
        end
        default: begin
          // Branches and everything else are dropped here
          uop_valid[i] = 1'b0;
        end
      endcase
      rd_valid[i] = writes && (rd[i*reg_index_width +: reg_index_width] != '0);
    end
  end

endmodule

//--- stall_hold_stage.sv
/*
  Stage register that parks one bundle while downstream is full
  and presents it again on the first cycle after
*/
`timescale 1ns/1ns

module stall_hold_stage #(
  parameter int decode_width = core_pkg::default_decode_width,
  parameter int payload_width = 1
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush,
  input  logic                     issue_full,
  input  logic [payload_width-1:0] data_in,
  input  logic [decode_width-1:0]  valid_in,
  output logic [payload_width-1:0] data_out,
  output logic [decode_width-1:0]  valid_out
);

  logic [payload_width-1:0] parked_data;
  logic [decode_width-1:0]  parked_valid;
  logic                     stall_prev;

  // Four cases on {issue_full, stall_prev}
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      valid_out    <= '0;
      parked_valid <= '0;
      stall_prev   <= 1'b0;
    end else begin
      case ({issue_full, stall_prev})
        2'b10: begin
          // First full cycle parks what decode offers
          valid_out    <= '0;
          parked_valid <= valid_in;
          stall_prev   <= 1'b1;
        end
        2'b01: begin
          // Full just dropped so the parked bundle goes out
          valid_out    <= parked_valid;
          parked_valid <= '0;
          stall_prev   <= 1'b0;
        end
        2'b11: valid_out <= '0;
        default: valid_out <= valid_in;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (issue_full && !stall_prev) begin
      parked_data <= data_in;
    end
    if (!issue_full) begin
      data_out <= stall_prev ? parked_data : data_in;
    end
  end

  // Parking only ever starts from an empty buffer
  assert property (@(posedge clock) disable iff (reset)
    (issue_full && !stall_prev) |-> parked_valid == '0);

endmodule

//--- scoreboard.sv
/*
  Busy bit per architectural register, set at dispatch, cleared at
  writeback, with operand lookup that sees earlier slots of the bundle
*/
`timescale 1ns/1ns

module scoreboard #(
  parameter int decode_width = core_pkg::default_decode_width,
  parameter int wb_ports = core_pkg::default_wb_ports
) (
  input  logic                                              clock,
  input  logic                                              reset,
  input  logic                                              flush,
  input  logic [decode_width-1:0]                           set_valid,
  input  logic [decode_width*core_pkg::reg_index_width-1:0] set_index,
  input  logic [wb_ports-1:0]                               wb_valid,
  input  logic [wb_ports*core_pkg::reg_index_width-1:0]     wb_index,
  input  logic [decode_width*core_pkg::reg_index_width-1:0] rs1,
  input  logic [decode_width*core_pkg::reg_index_width-1:0] rs2,
  output logic [decode_width-1:0]                           rs1_busy,
  output logic [decode_width-1:0]                           rs2_busy
);

  import core_pkg::*;

  logic [arch_regs-1:0] busy_bits;
  logic [arch_regs-1:0] busy_next;

  // Clears first so that a same-edge set wins
  always_comb begin
    busy_next = busy_bits;
    for (int w = 0; w < wb_ports; w++) begin
      if (wb_valid[w]) begin
        busy_next[wb_index[w*reg_index_width +: reg_index_width]] = 1'b0;
      end
    end
    for (int i = 0; i < decode_width; i++) begin
      if (set_valid[i]) begin
        busy_next[set_index[i*reg_index_width +: reg_index_width]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      busy_bits <= '0;
    end else begin
      busy_bits <= busy_next;
    end
  end

  // Lookup uses stored bits plus writers in lower slots of the same bundle
  always_comb begin
    logic [reg_index_width-1:0] src1;
    logic [reg_index_width-1:0] src2;
    logic [reg_index_width-1:0] dst;
    for (int i = 0; i < decode_width; i++) begin
      src1 = rs1[i*reg_index_width +: reg_index_width];
      src2 = rs2[i*reg_index_width +: reg_index_width];
      rs1_busy[i] = busy_bits[src1];
      rs2_busy[i] = busy_bits[src2];
      for (int j = 0; j < i; j++) begin
        dst = set_index[j*reg_index_width +: reg_index_width];
        if (set_valid[j] && dst == src1) rs1_busy[i] = 1'b1;
        if (set_valid[j] && dst == src2) rs2_busy[i] = 1'b1;
      end
      if (src1 == '0) rs1_busy[i] = 1'b0;
      if (src2 == '0) rs2_busy[i] = 1'b0;
    end
  end

  // Dispatch never requests register 0 as a destination
  assert property (@(posedge clock) disable iff (reset) busy_bits[0] == 1'b0);

endmodule

//--- dispatch_stage.sv
/*
  Routes held micro-ops into the integer and memory lanes by class,
  requests scoreboard sets and registers the lanes with busy tags
*/
`timescale 1ns/1ns

module dispatch_stage #(
  parameter int decode_width = core_pkg::default_decode_width
) (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic                                               flush,
  input  logic [decode_width-1:0]                            uop_valid,
  input  logic [decode_width*core_pkg::uop_class_width-1:0]  uop_class,
  input  logic [core_pkg::xlen-1:0]                          uop_pc,
  input  logic [decode_width*core_pkg::reg_index_width-1:0]  uop_rd,
  input  logic [decode_width-1:0]                            uop_rd_valid,
  input  logic [decode_width*core_pkg::reg_index_width-1:0]  uop_rs1,
  input  logic [decode_width*core_pkg::reg_index_width-1:0]  uop_rs2,
  input  logic [decode_width-1:0]                            uop_rs2_used,
  input  logic [decode_width*core_pkg::mem_offset_width-1:0] uop_mem_offset,
  input  logic [decode_width-1:0]                            rs1_busy,
  input  logic [decode_width-1:0]                            rs2_busy,
  output logic [decode_width-1:0]                            set_valid,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  set_index,
  output logic [decode_width-1:0]                            int_valid,
  output logic [decode_width*core_pkg::xlen-1:0]             int_pc,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  int_rd,
  output logic [decode_width-1:0]                            int_rd_valid,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  int_rs1,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  int_rs2,
  output logic [decode_width-1:0]                            int_rs1_busy,
  output logic [decode_width-1:0]                            int_rs2_busy,
  output logic [decode_width-1:0]                            mem_valid,
  output logic [decode_width-1:0]                            mem_is_store,
  output logic [decode_width*core_pkg::xlen-1:0]             mem_pc,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  mem_rd,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  mem_rs1,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  mem_rs2,
  output logic [decode_width*core_pkg::mem_offset_width-1:0] mem_offset,
  output logic [decode_width-1:0]                            mem_rs1_busy,
  output logic [decode_width-1:0]                            mem_rs2_busy
);

  import core_pkg::*;

  logic [decode_width-1:0]      to_int;
  logic [decode_width-1:0]      to_mem;
  logic [decode_width-1:0]      is_store;
  logic [decode_width-1:0]      src2_busy;
  logic [decode_width*xlen-1:0] slot_pc;

  // Every dispatched writer marks its destination busy
  assign set_valid = uop_valid & uop_rd_valid;
  assign set_index = uop_rd;
  assign src2_busy = rs2_busy & uop_rs2_used;

  always_comb begin
    logic [uop_class_width-1:0] cls;
    for (int i = 0; i < decode_width; i++) begin
      cls = uop_class[i*uop_class_width +: uop_class_width];
      is_store[i] = (cls == class_store);
      to_int[i] = uop_valid[i] && (cls == class_int);
      to_mem[i] = uop_valid[i] && (cls == class_load || cls == class_store);
      slot_pc[i*xlen +: xlen] = uop_pc + xlen'(4 * i);
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      int_valid <= '0;
      mem_valid <= '0;
    end else begin
      int_valid <= to_int;
      mem_valid <= to_mem;
    end
  end

  // Both lanes take the full payload and the lane valid selects the owner
  always_ff @(posedge clock) begin
    int_pc       <= slot_pc;
    int_rd       <= uop_rd;
    int_rd_valid <= uop_rd_valid;
    int_rs1      <= uop_rs1;
    int_rs2      <= uop_rs2;
    int_rs1_busy <= rs1_busy;
    int_rs2_busy <= src2_busy;
    mem_is_store <= is_store;
    mem_pc       <= slot_pc;
    mem_rd       <= uop_rd;
    mem_rs1      <= uop_rs1;
    mem_rs2      <= uop_rs2;
    mem_offset   <= uop_mem_offset;
    mem_rs1_busy <= rs1_busy;
    mem_rs2_busy <= src2_busy;
  end

  // Every valid slot goes to exactly one lane
  assert property (@(posedge clock) disable iff (reset) (to_int ^ to_mem) == uop_valid);

endmodule

//--- frontend_core.sv
/*
  Front-end top level: fetch latch, decode, hold stage, scoreboard
  and dispatch, with fetch-ready taken from the issue-full level
*/
`timescale 1ns/1ns

module frontend_core #(
  parameter int decode_width = core_pkg::default_decode_width,
  parameter int wb_ports = core_pkg::default_wb_ports
) (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic                                               fetch_valid,
  input  logic [core_pkg::xlen-1:0]                          fetch_pc,
  input  logic [decode_width*core_pkg::xlen-1:0]             fetch_data,
  input  logic [decode_width-1:0]                            fetch_slot_valid,
  input  logic                                               issue_full,
  input  logic                                               flush,
  input  logic [wb_ports-1:0]                                wb_valid,
  input  logic [wb_ports*core_pkg::reg_index_width-1:0]      wb_index,
  output logic                                               fetch_ready,
  output logic [decode_width-1:0]                            int_valid,
  output logic [decode_width*core_pkg::xlen-1:0]             int_pc,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  int_rd,
  output logic [decode_width-1:0]                            int_rd_valid,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  int_rs1,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  int_rs2,
  output logic [decode_width-1:0]                            int_rs1_busy,
  output logic [decode_width-1:0]                            int_rs2_busy,
  output logic [decode_width-1:0]                            mem_valid,
  output logic [decode_width-1:0]                            mem_is_store,
  output logic [decode_width*core_pkg::xlen-1:0]             mem_pc,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  mem_rd,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  mem_rs1,
  output logic [decode_width*core_pkg::reg_index_width-1:0]  mem_rs2,
  output logic [decode_width*core_pkg::mem_offset_width-1:0] mem_offset,
  output logic [decode_width-1:0]                            mem_rs1_busy,
  output logic [decode_width-1:0]                            mem_rs2_busy
);

  import core_pkg::*;

  localparam int rw = reg_index_width;
  localparam int payload_width =
    xlen + decode_width * (mem_offset_width + 3 * rw + 2 + uop_class_width);

  logic [decode_width*xlen-1:0]             inst;
  logic [xlen-1:0]                          inst_pc;
  logic [decode_width-1:0]                  inst_valid;
  logic [decode_width-1:0]                  dec_valid, dec_rd_valid, dec_rs2_used;
  logic [decode_width*uop_class_width-1:0]  dec_class;
  logic [decode_width*rw-1:0]               dec_rd, dec_rs1, dec_rs2;
  logic [decode_width*mem_offset_width-1:0] dec_offset;
  logic [payload_width-1:0]                 dec_payload, held_payload;
  logic [decode_width-1:0]                  held_valid, held_rd_valid, held_rs2_used;
  logic [decode_width*uop_class_width-1:0]  held_class;
  logic [xlen-1:0]                          held_pc;
  logic [decode_width*rw-1:0]               held_rd, held_rs1, held_rs2;
  logic [decode_width*mem_offset_width-1:0] held_offset;
  logic [decode_width-1:0]                  set_valid, rs1_busy, rs2_busy;
  logic [decode_width*rw-1:0]               set_index;

  assign fetch_ready = !issue_full;

  assign dec_payload = {inst_pc, dec_offset, dec_rs2_used, dec_rs2, dec_rs1,
                        dec_rd_valid, dec_rd, dec_class};
  assign {held_pc, held_offset, held_rs2_used, held_rs2, held_rs1,
          held_rd_valid, held_rd, held_class} = held_payload;

  fetch_latch #(.decode_width(decode_width)) u_fetch_latch (
    .clock(clock), .reset(reset), .flush(flush), .issue_full(issue_full),
    .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_data(fetch_data),
    .fetch_slot_valid(fetch_slot_valid),
    .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid)
  );

  inst_decode #(.decode_width(decode_width)) u_inst_decode (
    .inst(inst), .inst_valid(inst_valid), .uop_valid(dec_valid), .uop_class(dec_class),
    .rd(dec_rd), .rd_valid(dec_rd_valid), .rs1(dec_rs1), .rs2(dec_rs2),
    .rs2_used(dec_rs2_used), .mem_offset(dec_offset)
  );

  stall_hold_stage #(
    .decode_width(decode_width),
    .payload_width(payload_width)
  ) u_stall_hold_stage (
    .clock(clock), .reset(reset), .flush(flush), .issue_full(issue_full),
    .data_in(dec_payload), .valid_in(dec_valid),
    .data_out(held_payload), .valid_out(held_valid)
  );

  scoreboard #(.decode_width(decode_width), .wb_ports(wb_ports)) u_scoreboard (
    .clock(clock), .reset(reset), .flush(flush),
    .set_valid(set_valid), .set_index(set_index),
    .wb_valid(wb_valid), .wb_index(wb_index),
    .rs1(held_rs1), .rs2(held_rs2), .rs1_busy(rs1_busy), .rs2_busy(rs2_busy)
  );

  dispatch_stage #(.decode_width(decode_width)) u_dispatch_stage (
    .clock(clock), .reset(reset), .flush(flush),
    .uop_valid(held_valid), .uop_class(held_class), .uop_pc(held_pc),
    .uop_rd(held_rd), .uop_rd_valid(held_rd_valid), .uop_rs1(held_rs1),
    .uop_rs2(held_rs2), .uop_rs2_used(held_rs2_used), .uop_mem_offset(held_offset),
    .rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
    .set_valid(set_valid), .set_index(set_index),
    .int_valid(int_valid), .int_pc(int_pc), .int_rd(int_rd), .int_rd_valid(int_rd_valid),
    .int_rs1(int_rs1), .int_rs2(int_rs2),
    .int_rs1_busy(int_rs1_busy), .int_rs2_busy(int_rs2_busy),
    .mem_valid(mem_valid), .mem_is_store(mem_is_store), .mem_pc(mem_pc),
    .mem_rd(mem_rd), .mem_rs1(mem_rs1), .mem_rs2(mem_rs2), .mem_offset(mem_offset),
    .mem_rs1_busy(mem_rs1_busy), .mem_rs2_busy(mem_rs2_busy)
  );

endmodule

//--- tb_frontend_core.sv
/*
  Testbench for the front end: random bundles, stalls, writebacks and
  flushes, checked against a queue model with its own busy bits
*/
`timescale 1ns/1ns

module tb_frontend_core;

  import core_pkg::*;

  localparam int dw = default_decode_width;
  localparam int wp = default_wb_ports;
  localparam int rw = reg_index_width;
  localparam int quiet_cycles = 60;
  localparam int random_cycles = 600;
  localparam int drain_cycles = 20;
  localparam int stim_cycles = 10 + quiet_cycles + random_cycles + drain_cycles;
  localparam int cycle_limit = 4 * stim_cycles + 100;
  localparam logic [6:0] opcode_branch = 7'b1100011;

  logic                     clock = 1'b0;
  logic                     reset;
  logic                     fetch_valid;
  logic [xlen-1:0]          fetch_pc;
  logic [dw*xlen-1:0]       fetch_data;
  logic [dw-1:0]            fetch_slot_valid;
  logic                     issue_full;
  logic                     flush;
  logic [wp-1:0]            wb_valid;
  logic [wp*rw-1:0]         wb_index;
  logic                     fetch_ready;
  logic [dw-1:0]            int_valid;
  logic [dw*xlen-1:0]       int_pc;
  logic [dw*rw-1:0]         int_rd;
  logic [dw-1:0]            int_rd_valid;
  logic [dw*rw-1:0]         int_rs1;
  logic [dw*rw-1:0]         int_rs2;
  logic [dw-1:0]            int_rs1_busy;
  logic [dw-1:0]            int_rs2_busy;
  logic [dw-1:0]            mem_valid;
  logic [dw-1:0]            mem_is_store;
  logic [dw*xlen-1:0]       mem_pc;
  logic [dw*rw-1:0]         mem_rd;
  logic [dw*rw-1:0]         mem_rs1;
  logic [dw*rw-1:0]         mem_rs2;
  logic [dw*mem_offset_width-1:0] mem_offset;
  logic [dw-1:0]            mem_rs1_busy;
  logic [dw-1:0]            mem_rs2_busy;

  // Expected bundles in accept order
  logic [xlen-1:0]          exp_pc[$];
  logic [dw*xlen-1:0]       exp_words[$];
  logic [dw-1:0]            exp_mask[$];
  int                       exp_accept[$];
  logic [arch_regs-1:0]     model_busy = '0;
  logic [arch_regs-1:0]     dispatch_set;
  int                       edge_count = 0;
  int                       last_full = -1;
  int                       timeout_count = 0;
  int                       errors = 0;
  int                       checks = 0;

  frontend_core uut (.*);

  always #10 clock = ~clock;

  function automatic logic known_opcode(input logic [6:0] op);
    return op == opcode_op || op == opcode_op_imm || op == opcode_lui ||
           op == opcode_load || op == opcode_store;
  endfunction

  // Mostly low register numbers so that bundles depend on each other
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    int          pick;
    w = $urandom();
    pick = $urandom_range(0, 11);
    case (pick)
      0, 1, 2: w[6:0] = opcode_op;
      3, 4:    w[6:0] = opcode_op_imm;
      5:       w[6:0] = opcode_lui;
      6, 7:    w[6:0] = opcode_load;
      8, 9:    w[6:0] = opcode_store;
      default: w[6:0] = opcode_branch;
    endcase
    if ($urandom_range(0, 3) != 0) begin
      w[11:7] = 5'($urandom_range(0, 7));
      w[19:15] = 5'($urandom_range(0, 7));
      w[24:20] = 5'($urandom_range(0, 7));
    end
    return w;
  endfunction

  task automatic check_value(input string name, input int slot, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("Error: %s slot %0d is %h, expected %h", name, slot, got, want);
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Failure at edge %0d: %s", edge_count, what);
    end
  endtask

  // Oldest expected bundle against the lanes with busy flags from the model
  task automatic match_bundle();
    logic [xlen-1:0]      base;
    logic [dw*xlen-1:0]   words;
    logic [dw-1:0]        mask;
    logic [arch_regs-1:0] seen;
    logic [31:0]          w;
    logic [rw-1:0]        rd, rs1, rs2;
    logic [11:0]          offset;
    logic                 live, is_store, is_mem, writes, busy1, busy2;
    int                   accept;
    base = exp_pc.pop_front();
    words = exp_words.pop_front();
    mask = exp_mask.pop_front();
    accept = exp_accept.pop_front();
    require(edge_count - accept >= 2, "bundle reached the lanes before its third edge");
    require(edge_count - accept == 2 || last_full > accept,
            "bundle was delayed although issue_full stayed low");
    seen = model_busy;
    for (int i = 0; i < dw; i++) begin
      w = words[i*xlen +: xlen];
      live = mask[i] && known_opcode(w[6:0]);
      is_store = w[6:0] == opcode_store;
      is_mem = live && (is_store || w[6:0] == opcode_load);
      rd = is_store ? '0 : w[11:7];
      rs1 = (w[6:0] == opcode_lui) ? '0 : w[19:15];
      rs2 = (is_store || w[6:0] == opcode_op) ? w[24:20] : '0;
      offset = is_store ? {w[31:25], w[11:7]} : w[31:20];
      writes = live && !is_store && rd != '0;
      busy1 = rs1 != '0 && seen[rs1];
      busy2 = rs2 != '0 && seen[rs2];
      check_value("int_valid", i, 32'(int_valid[i]), 32'(live && !is_mem));
      check_value("mem_valid", i, 32'(mem_valid[i]), 32'(is_mem));
      if (live && !is_mem) begin
        check_value("int_pc", i, int_pc[i*xlen +: xlen], base + 32'(4 * i));
        check_value("int_rd", i, 32'(int_rd[i*rw +: rw]), 32'(rd));
        check_value("int_rd_valid", i, 32'(int_rd_valid[i]), 32'(writes));
        check_value("int_rs1", i, 32'(int_rs1[i*rw +: rw]), 32'(rs1));
        check_value("int_rs2", i, 32'(int_rs2[i*rw +: rw]), 32'(rs2));
        check_value("int_rs1_busy", i, 32'(int_rs1_busy[i]), 32'(busy1));
        check_value("int_rs2_busy", i, 32'(int_rs2_busy[i]), 32'(busy2));
      end
      if (is_mem) begin
        check_value("mem_is_store", i, 32'(mem_is_store[i]), 32'(is_store));
        check_value("mem_pc", i, mem_pc[i*xlen +: xlen], base + 32'(4 * i));
        check_value("mem_rd", i, 32'(mem_rd[i*rw +: rw]), 32'(rd));
        check_value("mem_rs1", i, 32'(mem_rs1[i*rw +: rw]), 32'(rs1));
        check_value("mem_rs2", i, 32'(mem_rs2[i*rw +: rw]), 32'(rs2));
        check_value("mem_offset", i, 32'(mem_offset[i*12 +: 12]), 32'(offset));
        check_value("mem_rs1_busy", i, 32'(mem_rs1_busy[i]), 32'(busy1));
        check_value("mem_rs2_busy", i, 32'(mem_rs2_busy[i]), 32'(busy2));
      end
      // Later slots of the same bundle see this writer
      if (writes) begin
        seen[rd] = 1'b1;
        dispatch_set[rd] = 1'b1;
      end
    end
  endtask

  task automatic record_accept();
    logic live;
    live = 1'b0;
    for (int i = 0; i < dw; i++) begin
      if (fetch_slot_valid[i] && known_opcode(fetch_data[i*xlen +: 7])) begin
        live = 1'b1;
      end
    end
    if (live) begin
      exp_pc.push_back(fetch_pc);
      exp_words.push_back(fetch_data);
      exp_mask.push_back(fetch_slot_valid);
      exp_accept.push_back(edge_count);
    end
  endtask

  // Inputs still hold what the DUT saw at the edge just passed
  task automatic observe_edge();
    logic out_any;
    logic due;
    edge_count++;
    if (issue_full) begin
      last_full = edge_count;
    end
    out_any = (int_valid | mem_valid) != '0;
    require(fetch_ready == !issue_full, "fetch_ready does not follow issue_full");
    if (reset) begin
      require(!out_any, "a lane is valid during reset");
    end
    due = 1'b0;
    if (exp_pc.size() > 0 && !reset && !flush) begin
      due = (exp_accept[0] + 2 == edge_count) && (last_full < exp_accept[0]);
    end
    dispatch_set = '0;
    if (out_any) begin
      if (exp_pc.size() == 0) begin
        require(1'b0, "lanes show a bundle that was never expected");
      end else begin
        match_bundle();
      end
    end else if (due) begin
      require(1'b0, "bundle missing from the lanes on its third edge");
    end
    if (reset || flush) begin
      model_busy = '0;
      exp_pc.delete();
      exp_words.delete();
      exp_mask.delete();
      exp_accept.delete();
    end else begin
      // Clears first so that a same-edge set wins
      for (int w = 0; w < wp; w++) begin
        if (wb_valid[w]) begin
          model_busy[wb_index[w*rw +: rw]] = 1'b0;
        end
      end
      model_busy = model_busy | dispatch_set;
      if (fetch_valid && !issue_full) begin
        record_accept();
      end
    end
  endtask

  task automatic next_edge();
    @(posedge clock);
    #1;
    observe_edge();
  endtask

  task automatic drive_inputs(input int full_pct, input int flush_pct);
    fetch_valid = $urandom_range(0, 99) < 80;
    fetch_pc = $urandom() & 32'hffff_fffc;
    fetch_slot_valid = dw'($urandom());
    for (int i = 0; i < dw; i++) begin
      fetch_data[i*xlen +: xlen] = random_word();
    end
    // Full tends to come in bursts
    if (full_pct == 0) begin
      issue_full = 1'b0;
    end else begin
      issue_full = $urandom_range(0, 99) < (issue_full ? 60 : full_pct);
    end
    flush = $urandom_range(0, 99) < flush_pct;
    wb_valid = wp'($urandom());
    for (int w = 0; w < wp; w++) begin
      wb_index[w*rw +: rw] = rw'($urandom_range(0, 7));
    end
  endtask

  initial begin
    void'($urandom(32'habb7));
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_data = '0;
    fetch_slot_valid = '0;
    issue_full = 1'b0;
    flush = 1'b0;
    wb_valid = '0;
    wb_index = '0;
    repeat (10) begin
      next_edge();
      issue_full = 1'($urandom_range(0, 1));
    end
    reset = 1'b0;
    // Steady flow first and then stalls and flushes
    repeat (quiet_cycles) begin
      next_edge();
      drive_inputs(0, 0);
    end
    repeat (random_cycles) begin
      next_edge();
      drive_inputs(35, 2);
    end
    fetch_valid = 1'b0;
    issue_full = 1'b0;
    flush = 1'b0;
    wb_valid = '0;
    repeat (drain_cycles) begin
      next_edge();
    end
    require(exp_pc.size() == 0, "accepted bundles never reached the lanes");
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  always @(posedge clock) begin
    timeout_count++;
    if (timeout_count > cycle_limit) begin
      $display("Timeout: run passed %0d cycles, checks: %0d, errors: %0d",
               cycle_limit, checks, errors);
      $display("Errors found");
      $finish;
    end
  end

endmodule

//--- frontend_core.f
core_pkg.sv
fetch_latch.sv
inst_decode.sv
stall_hold_stage.sv
scoreboard.sv
dispatch_stage.sv
frontend_core.sv
tb_frontend_core.sv

//--- run.sh
#!/bin/sh
# Build the front-end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_frontend_core -f frontend_core.f -o sim_frontend
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_frontend)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
  exit 0
fi
exit 1
